// File: src/board_cfg_pkg.sv
`default_nettype none

package board_cfg_pkg;

    // Flip-flops in every input synchroniser
    localparam int SYNC_STAGES = 2;

    // System reset length after a DTR rising edge
    localparam int DTR_PULSE_CYCLES = 4;
    // Wide enough to hold the pulse length
    localparam int DTR_CNT_WIDTH = $clog2(DTR_PULSE_CYCLES + 1);

    // LED afterglow in clk cycles after the last activity
    localparam int ACTIVITY_HOLD_CYCLES = 32;
    localparam int HOLD_CNT_WIDTH = $clog2(ACTIVITY_HOLD_CYCLES + 1);

    // CPU program counter width
    localparam int PC_WIDTH = 27;

    // First PC value outside the bootloader
    localparam logic [PC_WIDTH-1:0] BOOT_DONE_PC = 27'hC02522;

    // Synchronised interrupt and flag lines
    localparam int N_IRQ = 5;

    // usb0, usb1, eth, ps2, flash and gpu
    localparam int N_ACTIVITY = 6;

endpackage

`default_nettype wire

// File: src/board_types_pkg.sv
`default_nettype none

package board_types_pkg;

    // Board control levels after the synchroniser
    typedef struct packed {
        // Low while any reset pin or button is pressed
        logic nreset_ok;
        // Serial port opened by the host
        logic dtr;
        // DIP switch 0
        logic boot_mode;
        // DIP switch 1, high selects HDMI
        logic select_hdmi;
    } ctrl_in_t;

    // Peripheral interrupt lines and the GPU flag
    typedef struct packed {
        // CH376 bottom, low active
        logic spi1_nint;
        // CH376 top, low active
        logic spi2_nint;
        // W5500
        logic spi3_int;
        // General purpose pin on the expansion SPI
        logic spi4_gp;
        // GPU finished a frame
        logic frame_drawn;
    } irq_in_t;

    // Slot of each activity LED
    typedef enum logic [2:0] {
        act_usb0,
        act_usb1,
        act_eth,
        act_ps2,
        act_flash,
        act_gpu
    } activity_idx_t;

endpackage

`default_nettype wire

// File: src/board_if.sv
`default_nettype none

// Synchronised board levels from input_sync
interface sync_status_if;
    import board_types_pkg::*;

    // Reset pins, DTR and DIP switches
    ctrl_in_t ctrl;
    // Interrupt and frame flags
    irq_in_t  irq;

    // Written by the synchroniser
    modport sync_out (
        output ctrl,
        output irq
    );

    // Reset generator and LED block
    modport sync_in (
        input ctrl,
        input irq
    );
endinterface

// Activity strobes from the rest of the system
interface activity_if;
    // Chip selects, low active
    logic       flash_cs_n;
    logic       usb0_cs_n;
    logic       usb1_cs_n;
    logic       eth_cs_n;
    // PS/2 scan code ready
    logic       ps2_int;
    // One write enable per VRAM
    logic [3:0] vram_we;

    modport src (
        output flash_cs_n, usb0_cs_n, usb1_cs_n, eth_cs_n,
        output ps2_int,
        output vram_we
    );

    modport sink (
        input flash_cs_n, usb0_cs_n, usb1_cs_n, eth_cs_n,
        input ps2_int,
        input vram_we
    );
endinterface

`default_nettype wire

// File: src/sync_chain.sv
`default_nettype none

module sync_chain #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  payload_t d,
    output payload_t q
);
    import board_cfg_pkg::*;

    // One register per stage, whole payload moves together
    payload_t stage [SYNC_STAGES];

    always_ff @(posedge clk) begin
        // First stage may go metastable
        stage[0] <= d;
        for (int i = 1; i < SYNC_STAGES; i++) begin
            stage[i] <= stage[i-1];
        end
    end

    // Last stage is stable in the clk domain
    assign q = stage[SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: src/input_sync.sv
`default_nettype none

module input_sync (
    input  logic                  clk,
    input  logic                  nreset,
    input  logic                  btn_l_n,
    input  logic                  btn_r_n,
    input  logic                  dtr,
    input  logic [1:0]            dips,
    input  logic                  spi1_nint,
    input  logic                  spi2_nint,
    input  logic                  spi3_int,
    input  logic                  spi4_gp,
    input  logic                  frame_drawn,
    sync_status_if.sync_out       sync
);
    import board_cfg_pkg::*;
    import board_types_pkg::*;

    ctrl_in_t         ctrl_raw;
    logic [N_IRQ-1:0] irq_bits;
    irq_in_t          irq_raw;

    // Any pressed reset source pulls the level low
    assign ctrl_raw.nreset_ok   = nreset & btn_l_n & btn_r_n;
    assign ctrl_raw.dtr         = dtr;
    // DIP 0 picks the boot source
    assign ctrl_raw.boot_mode   = dips[0];
    // DIP 1 picks HDMI over composite
    assign ctrl_raw.select_hdmi = dips[1];

    // Packed in struct field order, MSB first
    assign irq_bits = {spi1_nint, spi2_nint, spi3_int, spi4_gp, frame_drawn};
    assign irq_raw  = irq_in_t'(irq_bits);

    // Control levels
    sync_chain #(
        .payload_t (ctrl_in_t)
    ) i_ctrl_sync (
        .clk (clk),
        .d   (ctrl_raw),
        .q   (sync.ctrl)
    );

    // Interrupt lines
    sync_chain #(
        .payload_t (irq_in_t)
    ) i_irq_sync (
        .clk (clk),
        .d   (irq_raw),
        .q   (sync.irq)
    );

endmodule

`default_nettype wire

// File: src/reset_gen.sv
`default_nettype none

module reset_gen (
    input  logic            clk,
    input  logic            reset,
    sync_status_if.sync_in  sync,
    output logic            sys_reset,
    output logic            spi1_rst,
    output logic            spi2_rst,
    output logic            spi3_nrst,
    output logic            led
);
    import board_cfg_pkg::*;

    logic                     dtr_prev;
    logic                     dtr_rise;
    logic [DTR_CNT_WIDTH-1:0] pulse_cnt;
    logic                     pulse_busy;

    // Host opened the serial port
    assign dtr_rise   = sync.ctrl.dtr & ~dtr_prev;
    assign pulse_busy = pulse_cnt != '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            // Line already high at startup is not an edge
            dtr_prev  <= sync.ctrl.dtr;
            pulse_cnt <= '0;
            // Board reset also clears the LED stretchers
            sys_reset <= 1'b1;
        end else begin
            dtr_prev <= sync.ctrl.dtr;
            // Edge cycle counts as the first pulse cycle
            if (dtr_rise) begin
                pulse_cnt <= DTR_CNT_WIDTH'(DTR_PULSE_CYCLES - 1);
            end else if (pulse_busy) begin
                pulse_cnt <= pulse_cnt - 1'b1;
            end
            // Pin reset or DTR pulse
            sys_reset <= ~sync.ctrl.nreset_ok | dtr_rise | pulse_busy;
        end
    end

    // CH376 resets are high active
    assign spi1_rst  = sys_reset;
    assign spi2_rst  = sys_reset;
    // W5500 reset is low active
    assign spi3_nrst = ~sys_reset;

    // Debug LED shows an open serial port
    assign led = sync.ctrl.dtr;

endmodule

`default_nettype wire

// File: src/activity_led.sv
`default_nettype none

module activity_led (
    input  logic clk,
    input  logic sys_reset,
    input  logic activity,
    output logic led
);
    import board_cfg_pkg::*;

    // Cycles left before the LED goes dark
    logic [HOLD_CNT_WIDTH-1:0] hold_cnt;

    always_ff @(posedge clk) begin
        if (sys_reset) begin
            hold_cnt <= '0;
        end else if (activity) begin
            // Reload for as long as activity lasts
            hold_cnt <= HOLD_CNT_WIDTH'(ACTIVITY_HOLD_CYCLES);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // Lit while any hold time is left
    // a single cycle strobe thus shows for the full hold time
    assign led = hold_cnt != '0;

endmodule

`default_nettype wire

// File: src/status_leds.sv
`default_nettype none

module status_leds (
    input  logic                              clk,
    input  logic                              sys_reset,
    sync_status_if.sync_in                    sync,
    activity_if.sink                          act,
    input  logic [board_cfg_pkg::PC_WIDTH-1:0] pc,
    input  logic                              qspi_mode,
    output logic                              led_booted,
    output logic                              led_hdmi,
    output logic                              led_qspi,
    output logic                              led_usb0,
    output logic                              led_usb1,
    output logic                              led_eth,
    output logic                              led_ps2,
    output logic                              led_flash,
    output logic                              led_gpu
);
    import board_cfg_pkg::*;
    import board_types_pkg::*;

    logic [N_ACTIVITY-1:0] activity;
    logic [N_ACTIVITY-1:0] act_led;

    // Chip selects are low active
    assign activity[act_usb0]  = ~act.usb0_cs_n;
    assign activity[act_usb1]  = ~act.usb1_cs_n;
    assign activity[act_eth]   = ~act.eth_cs_n;
    assign activity[act_flash] = ~act.flash_cs_n;
    // Scan code ready strobe
    assign activity[act_ps2]   = act.ps2_int;
    // Write to any VRAM
    assign activity[act_gpu]   = |act.vram_we;

    // One pulse stretcher per slot
    for (genvar i = 0; i < N_ACTIVITY; i++) begin : g_act
        activity_led i_activity_led (
            .clk       (clk),
            .sys_reset (sys_reset),
            .activity  (activity[i]),
            .led       (act_led[i])
        );
    end

    assign led_usb0  = act_led[act_usb0];
    assign led_usb1  = act_led[act_usb1];
    assign led_eth   = act_led[act_eth];
    assign led_ps2   = act_led[act_ps2];
    assign led_flash = act_led[act_flash];
    assign led_gpu   = act_led[act_gpu];

    // CPU has left the bootloader
    assign led_booted = (pc >= BOOT_DONE_PC) | sys_reset;

    // Lit for composite output
    assign led_hdmi = ~sync.ctrl.select_hdmi | sys_reset;

    // Lit while the flash runs in single SPI mode
    assign led_qspi = ~qspi_mode | sys_reset;

endmodule

`default_nettype wire

// File: src/board_ctrl_top.sv
`default_nettype none

module board_ctrl_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               nreset,
    input  logic                               btn_l_n,
    input  logic                               btn_r_n,
    input  logic                               dtr,
    input  logic [1:0]                         dips,
    input  logic                               spi1_nint,
    input  logic                               spi2_nint,
    input  logic                               spi3_int,
    input  logic                               spi4_gp,
    input  logic                               frame_drawn,
    input  logic [board_cfg_pkg::PC_WIDTH-1:0] pc,
    input  logic                               qspi_mode,
    input  logic                               flash_cs_n,
    input  logic                               usb0_cs_n,
    input  logic                               usb1_cs_n,
    input  logic                               eth_cs_n,
    input  logic                               ps2_int,
    input  logic [3:0]                         vram_we,
    output logic                               sys_reset,
    output logic                               spi1_rst,
    output logic                               spi2_rst,
    output logic                               spi3_nrst,
    output logic                               led,
    output logic                               led_booted,
    output logic                               led_hdmi,
    output logic                               led_qspi,
    output logic                               led_usb0,
    output logic                               led_usb1,
    output logic                               led_eth,
    output logic                               led_ps2,
    output logic                               led_flash,
    output logic                               led_gpu,
    output logic                               spi1_nint_s,
    output logic                               spi2_nint_s,
    output logic                               spi3_int_s,
    output logic                               spi4_gp_s,
    output logic                               frame_drawn_s,
    output logic                               boot_mode,
    output logic                               select_hdmi
);

    sync_status_if sync_if ();
    activity_if    act_if ();

    // Activity strobes onto the interface
    assign act_if.flash_cs_n = flash_cs_n;
    assign act_if.usb0_cs_n  = usb0_cs_n;
    assign act_if.usb1_cs_n  = usb1_cs_n;
    assign act_if.eth_cs_n   = eth_cs_n;
    assign act_if.ps2_int    = ps2_int;
    assign act_if.vram_we    = vram_we;

    // Synchronised levels for the CPU and memory unit
    assign spi1_nint_s   = sync_if.irq.spi1_nint;
    assign spi2_nint_s   = sync_if.irq.spi2_nint;
    assign spi3_int_s    = sync_if.irq.spi3_int;
    assign spi4_gp_s     = sync_if.irq.spi4_gp;
    assign frame_drawn_s = sync_if.irq.frame_drawn;
    assign boot_mode     = sync_if.ctrl.boot_mode;
    assign select_hdmi   = sync_if.ctrl.select_hdmi;

    input_sync i_input_sync (
        .clk         (clk),
        .nreset      (nreset),
        .btn_l_n     (btn_l_n),
        .btn_r_n     (btn_r_n),
        .dtr         (dtr),
        .dips        (dips),
        .spi1_nint   (spi1_nint),
        .spi2_nint   (spi2_nint),
        .spi3_int    (spi3_int),
        .spi4_gp     (spi4_gp),
        .frame_drawn (frame_drawn),
        .sync        (sync_if.sync_out)
    );

    // Global reset and peripheral reset pins
    reset_gen i_reset_gen (
        .clk       (clk),
        .reset     (reset),
        .sync      (sync_if.sync_in),
        .sys_reset (sys_reset),
        .spi1_rst  (spi1_rst),
        .spi2_rst  (spi2_rst),
        .spi3_nrst (spi3_nrst),
        .led       (led)
    );

    status_leds i_status_leds (
        .clk        (clk),
        .sys_reset  (sys_reset),
        .sync       (sync_if.sync_in),
        .act        (act_if.sink),
        .pc         (pc),
        .qspi_mode  (qspi_mode),
        .led_booted (led_booted),
        .led_hdmi   (led_hdmi),
        .led_qspi   (led_qspi),
        .led_usb0   (led_usb0),
        .led_usb1   (led_usb1),
        .led_eth    (led_eth),
        .led_ps2    (led_ps2),
        .led_flash  (led_flash),
        .led_gpu    (led_gpu)
    );

endmodule

`default_nettype wire

// File: testbench/tb_board_ctrl.sv
`default_nettype none

module tb_board_ctrl;
    timeunit 1ns;
    timeprecision 1ps;
    import board_cfg_pkg::*;
    import board_types_pkg::*;

    // Pin levels, then the settled outputs
    typedef struct packed {
        logic       nreset;
        logic       btn_l_n;
        logic       btn_r_n;
        logic [1:0] dips;
        logic       qspi_mode;
        logic       exp_rst;
        logic       exp_hdmi;
        logic       exp_qspi;
    } row_t;

    localparam int N_ROWS = 10;

    // nreset btn_l_n btn_r_n dips qspi_mode | sys_reset led_hdmi led_qspi
    row_t rows [N_ROWS] = '{
        9'b1_1_1_10_1_0_0_0,
        9'b0_1_1_10_1_1_1_1,
        9'b1_1_1_10_1_0_0_0,
        9'b1_0_1_01_0_1_1_1,
        9'b1_1_1_01_0_0_1_1,
        9'b1_1_0_11_1_1_1_1,
        9'b1_1_1_11_1_0_0_0,
        9'b1_1_1_00_0_0_1_1,
        9'b0_0_0_10_1_1_1_1,
        9'b1_1_1_10_1_0_0_0
    };

    // Same order as activity_idx_t
    string led_names [N_ACTIVITY] = '{
        "led_usb0", "led_usb1", "led_eth", "led_ps2", "led_flash", "led_gpu"
    };

    // DUT inputs
    logic                clk;
    logic                reset;
    logic                nreset, btn_l_n, btn_r_n, dtr;
    logic [1:0]          dips;
    logic                spi1_nint, spi2_nint, spi3_int, spi4_gp, frame_drawn;
    logic [PC_WIDTH-1:0] pc;
    logic                qspi_mode;
    logic                flash_cs_n, usb0_cs_n, usb1_cs_n, eth_cs_n, ps2_int;
    logic [3:0]          vram_we;
    // DUT outputs
    logic                sys_reset, spi1_rst, spi2_rst, spi3_nrst, led;
    logic                led_booted, led_hdmi, led_qspi;
    logic                led_usb0, led_usb1, led_eth, led_ps2, led_flash, led_gpu;
    logic                spi1_nint_s, spi2_nint_s, spi3_int_s, spi4_gp_s, frame_drawn_s;
    logic                boot_mode, select_hdmi;

    logic [31:0]         rng = 32'd60255;

    board_ctrl_top i_board_ctrl_top (.*);

    // 40 ns period
    always #20 clk = ~clk;

    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_irq(string name, irq_in_t got, irq_in_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_booted(logic [PC_WIDTH-1:0] pc_val, logic got, logic exp);
        if (got !== exp) begin
            $display("[ERROR] led_booted at pc %h: got %h, expected %h", pc_val, got, exp);
            fail_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Outputs settled, inputs may change now
    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    function automatic irq_in_t sync_irq();
        irq_in_t v;
        v.spi1_nint   = spi1_nint_s;
        v.spi2_nint   = spi2_nint_s;
        v.spi3_int    = spi3_int_s;
        v.spi4_gp     = spi4_gp_s;
        v.frame_drawn = frame_drawn_s;
        return v;
    endfunction

    function automatic logic led_of(activity_idx_t slot);
        case (slot)
            act_usb0:  return led_usb0;
            act_usb1:  return led_usb1;
            act_eth:   return led_eth;
            act_ps2:   return led_ps2;
            act_flash: return led_flash;
            default:   return led_gpu;
        endcase
    endfunction

    // Chip selects low active, GPU via one VRAM write strobe
    task automatic set_activity(activity_idx_t slot, logic on, logic [1:0] we_bit);
        case (slot)
            act_usb0:  usb0_cs_n = ~on;
            act_usb1:  usb1_cs_n = ~on;
            act_eth:   eth_cs_n = ~on;
            act_ps2:   ps2_int = on;
            act_flash: flash_cs_n = ~on;
            default:   vram_we = on ? 4'b0001 << we_bit : 4'b0000;
        endcase
    endtask

    initial begin
        row_t                prev;
        row_t                cur;
        logic                exp_rst_now;
        irq_in_t             exp_irq;
        irq_in_t             prev_irq;
        logic [1:0]          prev_dips;
        logic [PC_WIDTH-1:0] pc_val;
        logic                booted;
        int                  waited;

        clk = 1'b0;
        reset = 1'b1;
        {nreset, btn_l_n, btn_r_n, dips, qspi_mode} = {rows[0].nreset, rows[0].btn_l_n,
            rows[0].btn_r_n, rows[0].dips, rows[0].qspi_mode};
        dtr = 1'b0;
        {spi1_nint, spi2_nint, spi3_int, spi4_gp, frame_drawn} = '0;
        pc = '0;
        {flash_cs_n, usb0_cs_n, usb1_cs_n, eth_cs_n} = 4'hf;
        ps2_int = 1'b0;
        vram_we = 4'h0;
        repeat (2) tick();
        reset = 1'b0;

        // Activity LEDs start dark
        for (int o = 0; o < N_ACTIVITY; o++) begin
            check_bit(led_names[o], led_of(activity_idx_t'(o)), 1'b0);
        end

        // Reset pins, DIP switches and QSPI LED from the table
        for (int r = 0; r < N_ROWS; r++) begin
            prev = rows[(r == 0) ? 0 : r - 1];
            cur = rows[r];
            {nreset, btn_l_n, btn_r_n, dips, qspi_mode} = {cur.nreset, cur.btn_l_n,
                cur.btn_r_n, cur.dips, cur.qspi_mode};
            for (int c = 1; c <= SYNC_STAGES + 1; c++) begin
                tick();
                // Registered reset trails the DIP levels by a cycle
                exp_rst_now = (c <= SYNC_STAGES) ? prev.exp_rst : cur.exp_rst;
                check_bit("sys_reset", sys_reset, exp_rst_now);
                check_bit("spi1_rst", spi1_rst, exp_rst_now);
                check_bit("spi2_rst", spi2_rst, exp_rst_now);
                check_bit("spi3_nrst", spi3_nrst, ~exp_rst_now);
                check_bit("select_hdmi", select_hdmi,
                    (c < SYNC_STAGES) ? prev.dips[1] : cur.dips[1]);
                check_bit("boot_mode", boot_mode,
                    (c < SYNC_STAGES) ? prev.dips[0] : cur.dips[0]);
            end
            // pc is zero here
            check_bit("led_booted", led_booted, cur.exp_rst);
            check_bit("led_hdmi", led_hdmi, cur.exp_hdmi);
            check_bit("led_qspi", led_qspi, cur.exp_qspi);
        end

        // DTR rising edge, pulse of fixed length
        dtr = 1'b1;
        for (int c = 1; c <= SYNC_STAGES + DTR_PULSE_CYCLES + 3; c++) begin
            tick();
            check_bit("sys_reset", sys_reset,
                c > SYNC_STAGES && c <= SYNC_STAGES + DTR_PULSE_CYCLES);
            check_bit("led", led, c >= SYNC_STAGES);
        end
        // Falling edge, no pulse
        dtr = 1'b0;
        for (int c = 1; c <= SYNC_STAGES + DTR_PULSE_CYCLES + 3; c++) begin
            tick();
            check_bit("sys_reset", sys_reset, 1'b0);
            check_bit("led", led, c < SYNC_STAGES);
        end

        // Random interrupt and DIP patterns
        prev_irq = '0;
        prev_dips = dips;
        for (int i = 0; i < 12; i++) begin
            rng = xorshift32(rng);
            exp_irq = irq_in_t'(rng[N_IRQ-1:0]);
            spi1_nint = exp_irq.spi1_nint;
            spi2_nint = exp_irq.spi2_nint;
            spi3_int = exp_irq.spi3_int;
            spi4_gp = exp_irq.spi4_gp;
            frame_drawn = exp_irq.frame_drawn;
            dips = rng[9:8];
            for (int c = 1; c <= SYNC_STAGES; c++) begin
                tick();
                check_irq("irq outputs", sync_irq(), (c < SYNC_STAGES) ? prev_irq : exp_irq);
                check_bit("boot_mode", boot_mode, (c < SYNC_STAGES) ? prev_dips[0] : dips[0]);
                check_bit("select_hdmi", select_hdmi,
                    (c < SYNC_STAGES) ? prev_dips[1] : dips[1]);
            end
            prev_irq = exp_irq;
            prev_dips = dips;
        end

        // Boot LED, boundary first, then random pc on both sides
        for (int i = 0; i < 10; i++) begin
            rng = xorshift32(rng);
            case (i)
                0: begin
                    pc_val = BOOT_DONE_PC - 1'b1;
                    booted = 1'b0;
                end
                1: begin
                    pc_val = BOOT_DONE_PC;
                    booted = 1'b1;
                end
                default: begin
                    booted = rng[0];
                    pc_val = booted ? BOOT_DONE_PC + PC_WIDTH'(rng[31:12])
                                    : PC_WIDTH'(rng[31:8]) % BOOT_DONE_PC;
                end
            endcase
            pc = pc_val;
            tick();
            check_booted(pc_val, led_booted, booted);
        end

        // One-cycle strobe per slot, stretched by the hold time
        for (int s = 0; s < N_ACTIVITY; s++) begin
            rng = xorshift32(rng);
            set_activity(activity_idx_t'(s), 1'b1, rng[1:0]);
            tick();
            set_activity(activity_idx_t'(s), 1'b0, rng[1:0]);
            for (int o = 0; o < N_ACTIVITY; o++) begin
                check_bit(led_names[o], led_of(activity_idx_t'(o)), o == s);
            end
            repeat (ACTIVITY_HOLD_CYCLES - 1) tick();
            check_bit(led_names[s], led_of(activity_idx_t'(s)), 1'b1);
            waited = 0;
            while (led_of(activity_idx_t'(s)) !== 1'b0 && waited < 3) begin
                tick();
                waited++;
            end
            if (led_of(activity_idx_t'(s)) !== 1'b0) begin
                $display("%s did not go dark after the hold time", led_names[s]);
                fail_run();
            end
        end

        // Light every LED, then a pin reset must darken them all
        rng = xorshift32(rng);
        for (int s = 0; s < N_ACTIVITY; s++) begin
            set_activity(activity_idx_t'(s), 1'b1, rng[1:0]);
        end
        tick();
        for (int s = 0; s < N_ACTIVITY; s++) begin
            set_activity(activity_idx_t'(s), 1'b0, rng[1:0]);
        end
        nreset = 1'b0;
        repeat (SYNC_STAGES + 1) tick();
        check_bit("sys_reset", sys_reset, 1'b1);
        check_bit("led_booted", led_booted, 1'b1);
        check_bit("led_hdmi", led_hdmi, 1'b1);
        check_bit("led_qspi", led_qspi, 1'b1);
        tick();
        for (int o = 0; o < N_ACTIVITY; o++) begin
            check_bit(led_names[o], led_of(activity_idx_t'(o)), 1'b0);
        end
        nreset = 1'b1;
        repeat (SYNC_STAGES + 1) tick();
        check_bit("sys_reset", sys_reset, 1'b0);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
src/board_cfg_pkg.sv
src/board_types_pkg.sv
src/board_if.sv
src/sync_chain.sv
src/input_sync.sv
src/reset_gen.sv
src/activity_led.sv
src/status_leds.sv
src/board_ctrl_top.sv
testbench/tb_board_ctrl.sv
